// File: logic/kcpu_alu.sv
/* 8-bit ALU for add, sub, and, or, eor and the CC immediate ops */
`timescale 1ns/100ps
`default_nettype none

module kcpu_alu
    import kcpu_pkg::*;
(
    input  wire alu_fn_t  fn,
    input  wire op_t      op,
    input  wire    [7:0]  a,
    input  wire    [7:0]  b,
    input  wire    [7:0]  cc_in,
    output logic   [7:0]  res,
    output logic   [7:0]  cc_out
);

    logic [8:0] sum9, dif9;
    logic [4:0] half;  // low nibble sum for H

    assign sum9 = {1'b0, a} + {1'b0, b};
    assign dif9 = {1'b0, a} - {1'b0, b};
    assign half = {1'b0, a[3:0]} + {1'b0, b[3:0]};

    always_comb begin
        res    = a;
        cc_out = cc_in;
        case (op)
            OP_ANDCC: cc_out = cc_in & b;
            OP_ORCC:  cc_out = cc_in | b;
            OP_ALU: begin
                case (fn)
                    ALU_ADD: begin
                        res          = sum9[7:0];
                        cc_out[CC_H] = half[4];
                        cc_out[CC_C] = sum9[8];
                        cc_out[CC_V] = (a[7] == b[7]) && (res[7] != a[7]);
                    end
                    ALU_SUB: begin
                        res          = dif9[7:0];
                        cc_out[CC_C] = dif9[8];  // borrow
                        cc_out[CC_V] = (a[7] != b[7]) && (res[7] != a[7]);
                    end
                    ALU_AND: res = a & b;
                    ALU_OR:  res = a | b;
                    ALU_EOR: res = a ^ b;
                    default: ;
                endcase
                if (fn == ALU_AND || fn == ALU_OR || fn == ALU_EOR) cc_out[CC_V] = 1'b0;
                cc_out[CC_N] = res[7];
                cc_out[CC_Z] = res == 8'h00;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/kcpu_cmd_port.sv
/* four-phase req/ack command port
   captures a command, pulses start, returns the response on done */
`timescale 1ns/100ps
`default_nettype none

module kcpu_cmd_port
    import kcpu_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        req,
    output logic       ack,
    input  wire cmd_t  cmd,
    output rsp_t       rsp,
    output logic       start,
    output cmd_t       cur_cmd,
    input  wire        done,
    input  wire rsp_t  result
);

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_HOLD} state_t;

    state_t state;
    logic   req_q;  // sampled req

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            req_q <= 1'b0;
            ack   <= 1'b0;
            start <= 1'b0;
        end else begin
            req_q <= req;
            start <= 1'b0;
            case (state)
                ST_IDLE: if (req_q) begin
                    start <= 1'b1;
                    state <= ST_RUN;
                end
                ST_RUN: if (done) begin
                    ack   <= 1'b1;
                    state <= ST_HOLD;
                end
                ST_HOLD: if (!req_q) begin  // host released req
                    ack   <= 1'b0;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_q) cur_cmd <= cmd;
        if (state == ST_RUN && done)   rsp     <= result;
    end

endmodule

`default_nettype wire

// File: logic/kcpu_pkg.sv
/* register codes, opcodes, ALU functions and CC bit positions
   command, response and stack step structs */
`default_nettype none

package kcpu_pkg;

    // postbyte nibble codes in 6809 numbering
    typedef enum logic [3:0] {
        REG_D  = 4'h0,
        REG_X  = 4'h1,
        REG_Y  = 4'h2,
        REG_U  = 4'h3,
        REG_S  = 4'h4,
        REG_PC = 4'h5,
        REG_A  = 4'h8,
        REG_B  = 4'h9,
        REG_CC = 4'ha,
        REG_DP = 4'hb
    } reg_code_t;

    typedef enum logic [3:0] {
        OP_LOAD  = 4'd0,
        OP_TFR   = 4'd1,
        OP_EXG   = 4'd2,
        OP_ALU   = 4'd3,
        OP_ANDCC = 4'd4,
        OP_ORCC  = 4'd5,
        OP_PSH   = 4'd6,
        OP_PUL   = 4'd7,
        OP_READ  = 4'd8
    } op_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_EOR = 3'd4
    } alu_fn_t;

    localparam int CC_C = 0;  // carry / borrow
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;
    localparam int CC_I = 4;
    localparam int CC_H = 5;  // half carry
    localparam int CC_F = 6;
    localparam int CC_E = 7;

    typedef struct packed {
        op_t         op;
        alu_fn_t     fn;
        logic        acc_b;     // B instead of A
        logic        use_u;     // stack through U instead of S
        logic [ 7:0] postbyte;  // source nibble high, destination low
        logic [15:0] imm;
        logic [ 7:0] mask;      // push/pull set, bit 7 is PC
    } cmd_t;

    typedef struct packed {
        logic [15:0] data;
        logic [ 7:0] cc;
    } rsp_t;

    typedef struct packed {
        logic [7:0] sel;    // one-hot mask bit being moved
        logic       hilon;  // high byte phase
        logic       push;
        logic       pull;
        logic       use_u;
        logic [7:0] wdata;  // pulled byte
    } stk_req_t;

endpackage

`default_nettype wire

// File: logic/kcpu_regs.sv
/* register file with TFR/EXG muxes, push byte select,
   pull write decode and U/S stepping */
`timescale 1ns/100ps
`default_nettype none

module kcpu_regs
    import kcpu_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            start,
    input  wire cmd_t      cmd,
    input  wire     [ 7:0] alu_res,
    input  wire     [ 7:0] alu_cc,
    input  wire stk_req_t  stk,
    output logic    [15:0] src_val,
    output logic    [15:0] dst_val,
    output logic    [ 7:0] acc_val,
    output logic    [ 7:0] psh_byte,
    output logic    [15:0] sp,
    output logic    [ 7:0] cc,
    output logic    [15:0] rd_val
);

    logic [ 7:0] a, b, dp;
    logic [15:0] x, y, u, s, pc;
    logic [ 7:0] nx_a, nx_b, nx_dp, nx_cc;
    logic [15:0] nx_x, nx_y, nx_u, nx_s, nx_pc;
    logic [15:0] act_sp, other_sp;
    reg_code_t   src_code, dst_code;
    reg_code_t   wr_code [2];
    logic [15:0] wr_val  [2];
    logic        wr_en   [2];

    function automatic logic [15:0] reg_read(input reg_code_t code);
        case (code)
            REG_D:   return {a, b};
            REG_X:   return x;
            REG_Y:   return y;
            REG_U:   return u;
            REG_S:   return s;
            REG_PC:  return pc;
            REG_A:   return {8'hff, a};
            REG_B:   return {8'hff, b};
            REG_CC:  return {8'hff, cc};
            REG_DP:  return {8'hff, dp};
            default: return 16'h0000;
        endcase
    endfunction

    function automatic logic [15:0] set_byte(input logic [15:0] old, input logic hi,
                                             input logic [7:0] val);
        return hi ? {val, old[7:0]} : {old[15:8], val};
    endfunction

    assign src_code = reg_code_t'(cmd.postbyte[7:4]);
    assign dst_code = reg_code_t'(cmd.postbyte[3:0]);

    always_comb begin
        src_val = reg_read(src_code);
        dst_val = reg_read(dst_code);
    end

    assign acc_val  = cmd.acc_b ? b : a;
    assign rd_val   = cmd.op == OP_ALU  ? {8'h00, acc_val} :
                      cmd.op == OP_READ ? src_val : 16'h0000;

    assign act_sp   = stk.use_u ? u : s;
    assign other_sp = stk.use_u ? s : u;  // bit 6 of the mask
    assign sp       = stk.push ? act_sp - 16'd1 : act_sp;  // pre-decrement on push

    always_comb begin
        case (stk.sel)
            8'h01:   psh_byte = cc;
            8'h02:   psh_byte = a;
            8'h04:   psh_byte = b;
            8'h08:   psh_byte = dp;
            8'h10:   psh_byte = stk.hilon ? x[15:8] : x[7:0];
            8'h20:   psh_byte = stk.hilon ? y[15:8] : y[7:0];
            8'h40:   psh_byte = stk.hilon ? other_sp[15:8] : other_sp[7:0];
            default: psh_byte = stk.hilon ? pc[15:8] : pc[7:0];
        endcase
    end

    // port 1 is the second half of EXG and wins on overlap
    always_comb begin
        wr_code[0] = dst_code;
        wr_val[0]  = src_val;
        wr_en[0]   = 1'b0;
        wr_code[1] = src_code;
        wr_val[1]  = dst_val;
        wr_en[1]   = 1'b0;
        if (start) begin
            case (cmd.op)
                OP_LOAD: begin
                    wr_en[0]  = 1'b1;
                    wr_val[0] = cmd.imm;
                end
                OP_TFR:  wr_en[0] = 1'b1;
                OP_EXG: begin
                    wr_en[0] = 1'b1;
                    wr_en[1] = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        nx_a  = a;
        nx_b  = b;
        nx_dp = dp;
        nx_cc = cc;
        nx_x  = x;
        nx_y  = y;
        nx_u  = u;
        nx_s  = s;
        nx_pc = pc;
        for (int i = 0; i < 2; i++) begin
            if (wr_en[i]) begin
                case (wr_code[i])
                    REG_D: begin
                        nx_a = wr_val[i][15:8];
                        nx_b = wr_val[i][7:0];
                    end
                    REG_X:   nx_x  = wr_val[i];
                    REG_Y:   nx_y  = wr_val[i];
                    REG_U:   nx_u  = wr_val[i];
                    REG_S:   nx_s  = wr_val[i];
                    REG_PC:  nx_pc = wr_val[i];
                    REG_A:   nx_a  = wr_val[i][7:0];  // low byte only
                    REG_B:   nx_b  = wr_val[i][7:0];
                    REG_CC:  nx_cc = wr_val[i][7:0];
                    REG_DP:  nx_dp = wr_val[i][7:0];
                    default: ;                        // unused codes drop writes
                endcase
            end
        end
        if (start && cmd.op == OP_ALU) begin
            if (cmd.acc_b) nx_b = alu_res;
            else           nx_a = alu_res;
            nx_cc = alu_cc;
        end
        if (start && (cmd.op == OP_ANDCC || cmd.op == OP_ORCC)) nx_cc = alu_cc;

        if (stk.push) begin
            if (stk.use_u) nx_u = u - 16'd1;
            else           nx_s = s - 16'd1;
        end
        if (stk.pull) begin
            case (stk.sel)
                8'h01: nx_cc = stk.wdata;
                8'h02: nx_a  = stk.wdata;
                8'h04: nx_b  = stk.wdata;
                8'h08: nx_dp = stk.wdata;
                8'h10: nx_x  = set_byte(x, stk.hilon, stk.wdata);
                8'h20: nx_y  = set_byte(y, stk.hilon, stk.wdata);
                8'h40: begin
                    if (stk.use_u) nx_s = set_byte(s, stk.hilon, stk.wdata);
                    else           nx_u = set_byte(u, stk.hilon, stk.wdata);
                end
                default: nx_pc = set_byte(pc, stk.hilon, stk.wdata);
            endcase
            if (stk.use_u) nx_u = u + 16'd1;  // post-increment
            else           nx_s = s + 16'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a  <= 8'h00;
            b  <= 8'h00;
            dp <= 8'h00;
            cc <= 8'h00;
            x  <= 16'h0000;
            y  <= 16'h0000;
            u  <= 16'h0000;
            s  <= 16'h0000;
            pc <= 16'h0000;
        end else begin
            a  <= nx_a;
            b  <= nx_b;
            dp <= nx_dp;
            cc <= nx_cc;
            x  <= nx_x;
            y  <= nx_y;
            u  <= nx_u;
            s  <= nx_s;
            pc <= nx_pc;
        end
    end

endmodule

`default_nettype wire

// File: logic/kcpu_stack_ram.sv
/* single-port stack RAM with registered read */
`timescale 1ns/100ps
`default_nettype none

module kcpu_stack_ram #(
    parameter int STACK_AW = 8
) (
    input  wire                 clk,
    input  wire  [STACK_AW-1:0] addr,
    input  wire                 we,
    input  wire  [7:0]          wdata,
    output logic [7:0]          rdata
);

    logic [7:0] mem [2**STACK_AW];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        rdata <= mem[addr];  // old data on a write cycle
    end

endmodule

`default_nettype wire

// File: logic/kcpu_stack_seq.sv
/* push/pull sequencer, one byte per step in 6809 order,
   and the done pulse for every command */
`timescale 1ns/100ps
`default_nettype none

module kcpu_stack_seq
    import kcpu_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            start,
    input  wire cmd_t      cmd,
    input  wire     [7:0]  psh_byte,
    input  wire     [7:0]  rdata,
    output stk_req_t       stk,
    output logic           we,
    output logic    [7:0]  wdata,
    output logic           busy,
    output logic           done
);

    logic [7:0] mask_q, sel;
    logic       hilon_q, push_q, pull_q, use_u_q;
    logic       rd_phase;  // data cycle of a pulled byte
    logic       is_wide, byte_done, step, last;
    logic       is_stk;

    // push takes the highest set bit, pull the lowest
    always_comb begin
        sel = 8'h00;
        if (push_q) begin
            for (int i = 0; i < 8; i++) begin
                if (mask_q[i]) sel = 8'h01 << i;
            end
        end else begin
            sel = mask_q & (~mask_q + 8'h01);
        end
    end

    assign is_wide   = |sel[7:4];
    assign byte_done = !is_wide || (push_q ? hilon_q : !hilon_q);  // second byte of a pair
    assign step      = push_q || (pull_q && rd_phase);
    assign last      = byte_done && ((mask_q & ~sel) == 8'h00);
    assign is_stk    = (cmd.op == OP_PSH || cmd.op == OP_PUL) && |cmd.mask;

    assign stk.sel   = sel;
    assign stk.hilon = hilon_q;
    assign stk.push  = push_q;
    assign stk.pull  = pull_q && rd_phase;
    assign stk.use_u = use_u_q;
    assign stk.wdata = rdata;

    assign we    = push_q;
    assign wdata = psh_byte;
    assign busy  = push_q | pull_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mask_q   <= 8'h00;
            hilon_q  <= 1'b0;
            push_q   <= 1'b0;
            pull_q   <= 1'b0;
            use_u_q  <= 1'b0;
            rd_phase <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                mask_q   <= cmd.mask;
                use_u_q  <= cmd.use_u;
                rd_phase <= 1'b0;
                hilon_q  <= cmd.op == OP_PUL;  // pull starts on the high byte
                push_q   <= is_stk && cmd.op == OP_PSH;
                pull_q   <= is_stk && cmd.op == OP_PUL;
                done     <= !is_stk;
            end else begin
                if (pull_q) rd_phase <= !rd_phase;
                if (step) begin
                    if (byte_done) begin
                        mask_q  <= mask_q & ~sel;
                        hilon_q <= pull_q;
                    end else begin
                        hilon_q <= !hilon_q;
                    end
                    if (last) begin
                        push_q <= 1'b0;
                        pull_q <= 1'b0;
                        done   <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/kcpu_unit.sv
/* register-and-stack unit top with the port, register file, ALU,
   stack sequencer and stack RAM */
`timescale 1ns/100ps
`default_nettype none

module kcpu_unit
    import kcpu_pkg::*;
#(
    parameter int STACK_AW = 8
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        req,
    output logic       ack,
    input  wire cmd_t  cmd,
    output rsp_t       rsp
);

    cmd_t        cur_cmd;
    rsp_t        result;
    stk_req_t    stk;
    logic        start, done, ram_we;
    logic [15:0] sp, rd_val;
    logic [ 7:0] acc_val, psh_byte, cc, alu_res, alu_cc, ram_rdata, ram_wdata;

    assign result = '{data: rd_val, cc: cc};

    kcpu_cmd_port u_port (
        .clk, .rst, .req, .ack, .cmd, .rsp,
        .start, .cur_cmd, .done, .result
    );

    kcpu_regs u_regs (
        .clk, .rst, .start,
        .cmd      (cur_cmd),
        .alu_res, .alu_cc, .stk,
        .src_val  (),
        .dst_val  (),
        .acc_val, .psh_byte, .sp, .cc, .rd_val
    );

    kcpu_alu u_alu (
        .fn     (cur_cmd.fn),
        .op     (cur_cmd.op),
        .a      (acc_val),
        .b      (cur_cmd.imm[7:0]),  // immediate operand
        .cc_in  (cc),
        .res    (alu_res),
        .cc_out (alu_cc)
    );

    kcpu_stack_seq u_seq (
        .clk, .rst, .start,
        .cmd      (cur_cmd),
        .psh_byte,
        .rdata    (ram_rdata),
        .stk,
        .we       (ram_we),
        .wdata    (ram_wdata),
        .busy     (),
        .done
    );

    kcpu_stack_ram #(.STACK_AW(STACK_AW)) u_ram (
        .clk,
        .addr  (sp[STACK_AW-1:0]),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// File: project.f
logic/kcpu_pkg.sv
logic/kcpu_cmd_port.sv
logic/kcpu_regs.sv
logic/kcpu_alu.sv
logic/kcpu_stack_seq.sv
logic/kcpu_stack_ram.sv
logic/kcpu_unit.sv
test/kcpu_checker.sv
test/tb_kcpu.sv

// File: run.sh
#!/bin/sh
# build and run the kcpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_kcpu -f project.f -o Vtb_kcpu
./obj_dir/Vtb_kcpu | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/kcpu_checker.sv
/* reference model of the registers and the stack RAM,
   compares every response and watches the handshake */
`timescale 1ns/100ps
`default_nettype none

module kcpu_checker
    import kcpu_pkg::*;
#(
    parameter int STACK_AW = 8
) (
    input wire       clk,
    input wire       rst,
    input wire       req,
    input wire       ack,
    input wire cmd_t cmd,
    input wire rsp_t rsp
);

    string       test_name = "reset";
    int          val_errors = 0;
    int          proto_errors = 0;
    logic [7:0]  m_a, m_b, m_dp, m_cc;
    logic [15:0] m_x, m_y, m_u, m_s, m_pc;
    logic [7:0]  m_mem [2**STACK_AW];
    logic        req_q, ack_q, pending;
    int          cyc, req_cyc;
    rsp_t        exp_rsp;
    cmd_t        act_cmd;

    function automatic logic [15:0] reg_get(input logic [3:0] code);
        case (code)
            4'h0:    return {m_a, m_b};
            4'h1:    return m_x;
            4'h2:    return m_y;
            4'h3:    return m_u;
            4'h4:    return m_s;
            4'h5:    return m_pc;
            4'h8:    return {8'hff, m_a};
            4'h9:    return {8'hff, m_b};
            4'ha:    return {8'hff, m_cc};
            4'hb:    return {8'hff, m_dp};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic reg_set(input logic [3:0] code, input logic [15:0] v);
        case (code)
            4'h0: begin
                m_a = v[15:8];
                m_b = v[7:0];
            end
            4'h1:    m_x  = v;
            4'h2:    m_y  = v;
            4'h3:    m_u  = v;
            4'h4:    m_s  = v;
            4'h5:    m_pc = v;
            4'h8:    m_a  = v[7:0];
            4'h9:    m_b  = v[7:0];
            4'ha:    m_cc = v[7:0];
            4'hb:    m_dp = v[7:0];
            default: ;
        endcase
    endtask

    // mask bit to register code with bit 6 as the other pointer
    function automatic logic [3:0] bit_code(input int i, input logic use_u);
        case (i)
            0:       return 4'ha;
            1:       return 4'h8;
            2:       return 4'h9;
            3:       return 4'hb;
            4:       return 4'h1;
            5:       return 4'h2;
            6:       return use_u ? 4'h4 : 4'h3;
            default: return 4'h5;
        endcase
    endfunction

    // flags from integer range checks on the operands
    task automatic alu_model(input alu_fn_t fn, input logic [7:0] x, input logic [7:0] y,
                             output logic [7:0] r);
        int ux, uy, sx, sy;
        ux = x;
        uy = y;
        sx = $signed(x);
        sy = $signed(y);
        case (fn)
            ALU_ADD: begin
                r = 8'(ux + uy);
                m_cc[CC_C] = ux + uy > 255;
                m_cc[CC_H] = (ux % 16) + (uy % 16) > 15;
                m_cc[CC_V] = sx + sy > 127 || sx + sy < -128;
            end
            ALU_SUB: begin
                r = 8'(ux - uy);
                m_cc[CC_C] = ux < uy;
                m_cc[CC_V] = sx - sy > 127 || sx - sy < -128;
            end
            ALU_AND: r = x & y;
            ALU_OR:  r = x | y;
            default: r = x ^ y;
        endcase
        if (fn != ALU_ADD && fn != ALU_SUB) m_cc[CC_V] = 1'b0;
        m_cc[CC_N] = r[7];
        m_cc[CC_Z] = r == 8'h00;
    endtask

    task automatic apply_cmd(input cmd_t c, output rsp_t e);
        logic [15:0] p, v, sv, dv;
        logic [7:0]  r;
        logic [3:0]  rc;
        e = '0;
        p = c.use_u ? m_u : m_s;
        case (c.op)
            OP_LOAD: reg_set(c.postbyte[3:0], c.imm);
            OP_TFR:  reg_set(c.postbyte[3:0], reg_get(c.postbyte[7:4]));
            OP_EXG: begin
                sv = reg_get(c.postbyte[7:4]);
                dv = reg_get(c.postbyte[3:0]);
                reg_set(c.postbyte[3:0], sv);
                reg_set(c.postbyte[7:4], dv);  // source write lands last
            end
            OP_ALU: begin
                alu_model(c.fn, c.acc_b ? m_b : m_a, c.imm[7:0], r);
                if (c.acc_b) m_b = r;
                else         m_a = r;
                e.data = {8'h00, r};
            end
            OP_ANDCC: m_cc = m_cc & c.imm[7:0];
            OP_ORCC:  m_cc = m_cc | c.imm[7:0];
            OP_PSH: begin
                for (int i = 7; i >= 0; i--) begin
                    if (c.mask[i]) begin
                        v = reg_get(bit_code(i, c.use_u));
                        p = p - 16'd1;
                        m_mem[p[STACK_AW-1:0]] = v[7:0];
                        if (i >= 4) begin
                            p = p - 16'd1;
                            m_mem[p[STACK_AW-1:0]] = v[15:8];
                        end
                    end
                end
                if (c.use_u) m_u = p;
                else         m_s = p;
            end
            OP_PUL: begin
                for (int i = 0; i < 8; i++) begin
                    if (c.mask[i]) begin
                        rc = bit_code(i, c.use_u);
                        v  = {8'h00, m_mem[p[STACK_AW-1:0]]};
                        p  = p + 16'd1;
                        if (i >= 4) begin
                            v = {v[7:0], m_mem[p[STACK_AW-1:0]]};  // high byte first
                            p = p + 16'd1;
                        end
                        reg_set(rc, v);
                    end
                end
                if (c.use_u) m_u = p;
                else         m_s = p;
            end
            OP_READ: e.data = reg_get(c.postbyte[7:4]);
            default: ;
        endcase
        e.cc = m_cc;
    endtask

    task automatic check_val(input string what, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            val_errors++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic fault(input string what);
        proto_errors++;
        $display("[%s] protocol fault: %s", test_name, what);
    endtask

    always @(negedge rst) begin
        if (ack !== 1'b0) fault("ack not low after reset");
    end

    // inputs move 0.5 ns after the edge, so the edge sees settled values
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            {m_a, m_b, m_dp, m_cc} = '0;
            {m_x, m_y, m_u, m_s, m_pc} = '0;
            req_q   = 1'b0;
            ack_q   = 1'b0;
            pending = 1'b0;
            cyc     = 0;
            req_cyc = 0;
        end else begin
            cyc++;
            if (req && !req_q) begin
                if (ack) fault("req rose while ack was still high");
                req_cyc = cyc;
                act_cmd = cmd;
                apply_cmd(cmd, exp_rsp);
                pending = 1'b1;
            end
            // ack is set at an edge and first seen one edge later
            if (ack && !ack_q) begin
                if (!req_q) fault("ack rose while req was low");
                if (!pending) begin
                    fault("ack rose with no command outstanding");
                end else begin
                    if (act_cmd.op != OP_PSH && act_cmd.op != OP_PUL &&
                        cyc - req_cyc - 1 != 3) begin
                        fault($sformatf("ack latency %0d cycles instead of 3",
                                        cyc - req_cyc - 1));
                    end
                    check_val($sformatf("%s data", act_cmd.op.name()),
                              exp_rsp.data, rsp.data);
                    check_val($sformatf("%s cc", act_cmd.op.name()),
                              {8'h00, exp_rsp.cc}, {8'h00, rsp.cc});
                    pending = 1'b0;
                end
            end
            if (!ack && ack_q && req_q) fault("ack fell while req was still high");
            req_q = req;
            ack_q = ack;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_kcpu.sv
/* testbench top with clock, reset, LFSR stimulus, four-phase host driver,
   watchdog, DUT and checker instances */
`timescale 1ns/100ps
`default_nettype none

module tb_kcpu
    import kcpu_pkg::*;
;

    localparam int STACK_AW = 8;
    localparam int N_CMDS   = 32 + 60 + 50 + 380 + 416;  // commands over all tests
    localparam int RST_CYC  = 10;

    logic        clk;
    logic        rst;
    logic        req;
    logic        ack;
    cmd_t        cmd;
    rsp_t        rsp;
    logic [31:0] lfsr;
    int          n_sent;

    kcpu_unit #(.STACK_AW(STACK_AW)) dut (
        .clk, .rst, .req, .ack, .cmd, .rsp
    );

    kcpu_checker #(.STACK_AW(STACK_AW)) chk (
        .clk,
        .rst,
        .req (dut.req),
        .ack (dut.ack),
        .cmd (dut.cmd),
        .rsp (dut.rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2, 1; one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic cmd_t mk_cmd(input op_t op, input logic [7:0] pb,
                                    input logic [15:0] imm);
        cmd_t c;
        c          = '0;
        c.op       = op;
        c.fn       = ALU_ADD;
        c.postbyte = pb;
        c.imm      = imm;
        return c;
    endfunction

    // four-phase host side with inputs changed 0.5 ns after the edge
    task automatic send(input cmd_t c);
        cmd = c;
        req = 1'b1;
        do begin
            @(posedge clk);
            #0.5;
        end while (!ack);
        req = 1'b0;
        do begin
            @(posedge clk);
            #0.5;
        end while (ack);
        n_sent++;
    endtask

    task automatic load_rand(input logic [3:0] code);
        logic [31:0] r;
        r = rand_bits(16);
        send(mk_cmd(OP_LOAD, {4'h0, code}, r[15:0]));
    endtask

    task automatic read_reg(input logic [3:0] code);
        send(mk_cmd(OP_READ, {code, 4'h0}, 16'h0000));
    endtask

    task automatic read_sweep();
        for (int k = 0; k < 12; k++) read_reg(4'(k));
    endtask

    task automatic stack_pair(input logic use_u, input logic [7:0] mask, input int n_mid);
        cmd_t        c;
        logic [31:0] r;
        logic [3:0]  act;
        act = use_u ? 4'h3 : 4'h4;
        c = mk_cmd(OP_PSH, 8'h00, 16'h0000);
        c.use_u = use_u;
        c.mask  = mask;
        send(c);
        for (int k = 0; k < n_mid; k++) begin
            do r = rand_bits(4); while (r[3:0] == act);  // keep the pointer
            load_rand(r[3:0]);
        end
        c.op = OP_PUL;
        send(c);
    endtask

    task automatic rand_alu();
        cmd_t        c;
        logic [31:0] r;
        r = rand_bits(16);
        c = mk_cmd(OP_ALU, 8'h00, {8'h00, r[7:0]});
        c.acc_b = r[8];
        r = rand_bits(3);
        c.fn = alu_fn_t'(r % 5);
        send(c);
    endtask

    task automatic rand_mixed();
        logic [31:0] r;
        logic [31:0] v;
        logic [7:0]  m;
        r = rand_bits(4);
        v = rand_bits(16);
        case (r % 9)
            0:       load_rand(v[3:0]);
            1:       send(mk_cmd(OP_TFR, v[7:0], 16'h0000));
            2:       send(mk_cmd(OP_EXG, v[7:0], 16'h0000));
            3:       rand_alu();
            4:       send(mk_cmd(OP_ANDCC, 8'h00, {8'h00, v[7:0]}));
            5:       send(mk_cmd(OP_ORCC, 8'h00, {8'h00, v[7:0]}));
            6, 7: begin
                m = v[7:0];
                if (m == 8'h00) m = 8'h81;
                stack_pair(v[8], m, 0);
            end
            default: read_reg(v[3:0]);
        endcase
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  m;
        lfsr   = 32'h9830f0d0;
        n_sent = 0;
        rst    = 1'b1;
        req    = 1'b0;
        cmd    = '0;
        repeat (RST_CYC) @(posedge clk);
        #0.5;
        rst = 1'b0;
        @(posedge clk);
        #0.5;

        chk.test_name = "load_read";
        for (int k = 0; k < 16; k++) begin
            load_rand(4'(k));
            read_reg(4'(k));
        end

        chk.test_name = "tfr_exg";
        for (int k = 0; k < 30; k++) begin
            r = rand_bits(16);
            send(mk_cmd(OP_TFR, r[7:0], 16'h0000));
            send(mk_cmd(OP_EXG, r[15:8], 16'h0000));
        end

        chk.test_name = "alu";
        for (int k = 0; k < 40; k++) rand_alu();
        for (int k = 0; k < 10; k++) begin
            r = rand_bits(9);
            send(mk_cmd(r[8] ? OP_ORCC : OP_ANDCC, 8'h00, {8'h00, r[7:0]}));
        end

        chk.test_name = "push_pull";
        for (int k = 0; k < 20; k++) begin
            load_rand(4'h3);
            load_rand(4'h4);
            r = rand_bits(9);
            m = r[7:0];
            if (m == 8'h00) m = 8'h40;
            stack_pair(r[8], m, 3);
            read_sweep();
        end

        chk.test_name = "mixed";
        while (n_sent < 522 + 400) rand_mixed();
        for (int k = 0; k < 16; k++) read_reg(4'(k));

        repeat (4) @(posedge clk);
        $display("value errors: %0d, protocol errors: %0d",
                 chk.val_errors, chk.proto_errors);
        if (chk.val_errors == 0 && chk.proto_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized from the command count
    initial begin
        repeat (N_CMDS * 40 + RST_CYC + 20) @(posedge clk);
        $display("run timed out after %0d commands", n_sent);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
